//--- project.f
common/spmv_pkg.sv
hw/cae_decode.sv
hw/aeg_regs.sv
pe_chain/pe_issue.sv
pe_chain/spmv_pe.sv
pe_chain/pe_collect.sv
hw/cae_pers_top.sv
verif/tb_cae_pers.sv

//--- Makefile
# Verilator build and run for the coprocessor dispatch testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_cae_pers"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps \
		-f project.f --top-module tb_cae_pers -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_cae_pers)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

//--- verif/tb_cae_pers.sv
`timescale 1ns/1ps

module tb_cae_pers;
   import spmv_pkg::*;

   localparam int N_PE           = 4;
   localparam int PE_STAGES      = 2;
   localparam int N_TESTS        = 6;
   localparam int DRAIN_LIMIT    = N_PE * PE_STAGES + 20;
   localparam int TIMEOUT_CYCLES = N_TESTS * DRAIN_LIMIT * 4;

   logic        clk;
   logic        r_reset;
   cae_inst_t   cae_inst_i;
   logic [63:0] cae_data_i;
   logic        cae_inst_vld_i;
   logic [63:0] cae_ret_data_o;
   logic        cae_ret_data_vld_o;
   cae_exc_t    cae_exception_o;
   logic        cae_idle_o;
   logic        cae_stall_o;

   // expected response is launched with the instruction and delayed one cycle
   cae_exc_t    exp_exc_drv;
   logic        exp_rd_drv;
   logic [63:0] exp_data_drv;
   cae_exc_t    exc_pipe;
   logic        rd_pipe;
   logic [63:0] data_pipe;

   logic [63:0] model_aeg [N_AEG];
   logic [47:0] model_acc [N_PE];
   logic [31:0] lfsr_state;
   string       cur_test;
   int          err_count;
   int          check_count;
   int          test_count;
   int          test_err0;

   cae_pers_top #(
      .N_PE      (N_PE),
      .PE_STAGES (PE_STAGES)
   ) u_dut (
      .clk                (clk),
      .r_reset            (r_reset),
      .cae_inst_i         (cae_inst_i),
      .cae_data_i         (cae_data_i),
      .cae_inst_vld_i     (cae_inst_vld_i),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .cae_exception_o    (cae_exception_o),
      .cae_idle_o         (cae_idle_o),
      .cae_stall_o        (cae_stall_o)
   );

   always #2 clk = ~clk;

   // ******************************
   // random data and reference
   // ******************************

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      logic        b;
      r = '0;
      for (int i = 0; i < n; i++) begin
         b = lfsr_state[0];
         lfsr_state = {1'b0, lfsr_state[31:1]};
         if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
         end
         r = {r[62:0], b};
      end
      return r;
   endfunction

   function automatic logic [63:0] make_word(input logic [3:0] op, input logic [3:0] pe,
                                             input logic [55:0] body);
      return {op, pe, body};
   endfunction

   // updates the accumulators and returns the word left in AEG0
   function automatic logic [63:0] ref_chain(input logic [63:0] word);
      logic [3:0]  op;
      logic [3:0]  pe;
      logic [47:0] operand;
      logic [63:0] result;
      op      = word[63:60];
      pe      = word[59:56];
      operand = word[47:0];
      result  = word;
      for (int i = 0; i < N_PE; i++) begin
         if (op == OP_RST) begin
            model_acc[i] = '0;
         end else if (op == OP_ADD && (pe == 4'(i) || pe == PE_BROADCAST)) begin
            model_acc[i] = model_acc[i] + operand;
         end else if (op == OP_RETURN && pe == 4'(i)) begin
            result = {op, pe, 8'h00, model_acc[i]};
         end
      end
      return result;
   endfunction

   // ******************************
   // compare
   // ******************************

   task automatic check_word(input string what, input logic [63:0] exp, input logic [63:0] act);
      check_count++;
      if (act !== exp) begin
         $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_exc(input string what, input cae_exc_t exp, input cae_exc_t act);
      check_count++;
      if (act !== exp) begin
         $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
         err_count++;
      end
   endtask

   always @(posedge clk) begin
      exc_pipe  <= exp_exc_drv;
      rd_pipe   <= exp_rd_drv;
      data_pipe <= exp_data_drv;
   end

   always @(negedge clk) begin
      if (!r_reset) begin
         check_exc("exception", exc_pipe, cae_exception_o);
         check_flag("return valid", rd_pipe, cae_ret_data_vld_o);
         if (rd_pipe) begin
            check_word("return data", data_pipe, cae_ret_data_o);
         end
      end
   end

   // ******************************
   // host side
   // ******************************

   task automatic send_inst(input logic [2:0] kind, input logic [4:0] caep, input int idx,
                            input logic [63:0] data, input cae_exc_t exc, input logic rd,
                            input logic [63:0] rd_data);
      cae_inst_t inst;
      inst         = '0;
      inst.kind    = kind;
      inst.caep    = caep;
      inst.aeg_idx = 18'(idx);
      @(posedge clk);
      cae_inst_i     <= inst;
      cae_data_i     <= data;
      cae_inst_vld_i <= 1'b1;
      exp_exc_drv    <= exc;
      exp_rd_drv     <= rd;
      exp_data_drv   <= rd_data;
      @(posedge clk);
      cae_inst_vld_i <= 1'b0;
      exp_exc_drv    <= '0;
      exp_rd_drv     <= 1'b0;
      @(negedge clk);
   endtask

   task automatic write_aeg(input int idx, input logic [63:0] data);
      cae_exc_t exc;
      exc = '0;
      if (idx < N_AEG) begin
         model_aeg[idx] = data;
      end else begin
         exc.aegidx_err = 1'b1;
      end
      send_inst(KIND_AEG_WR, 5'd0, idx, data, exc, 1'b0, '0);
   endtask

   task automatic read_aeg(input int idx);
      cae_exc_t exc;
      exc = '0;
      if (idx < N_AEG) begin
         send_inst(KIND_AEG_RD, 5'd0, idx, '0, exc, 1'b1, model_aeg[idx]);
      end else begin
         exc.aegidx_err = 1'b1;
         send_inst(KIND_AEG_RD, 5'd0, idx, '0, exc, 1'b0, '0);
      end
   endtask

   // issue AEG0 and wait for the chain to drain
   task automatic run_issue();
      logic [63:0] exp;
      int          cyc;
      exp = ref_chain(model_aeg[0]);
      send_inst(KIND_CUSTOM, CAEP_ISSUE, 0, '0, '0, 1'b0, '0);
      check_flag("stall after issue", 1'b1, cae_stall_o);
      check_flag("idle after issue", 1'b0, cae_idle_o);
      cyc = 0;
      while (cae_idle_o !== 1'b1 && cyc < DRAIN_LIMIT) begin
         check_flag("stall while busy", 1'b1, cae_stall_o);
         @(negedge clk);
         cyc++;
      end
      if (cae_idle_o !== 1'b1) begin
         $display("%s: the chain did not return to idle within %0d cycles", cur_test,
                  DRAIN_LIMIT);
         err_count++;
      end
      check_flag("stall after drain", 1'b0, cae_stall_o);
      model_aeg[0] = exp;
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_err0 = err_count;
   endtask

   task automatic end_test();
      @(posedge clk);
      @(negedge clk);
      test_count++;
      if (err_count == test_err0) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: %0d errors", cur_test, err_count - test_err0);
      end
   endtask

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      logic [63:0] tmp;
      logic [63:0] r;
      logic [3:0]  pe;
      r_reset        = 1'b1;
      clk            = 1'b0;
      cae_inst_i     = '0;
      cae_data_i     = '0;
      cae_inst_vld_i = 1'b0;
      exp_exc_drv    = '0;
      exp_rd_drv     = 1'b0;
      exp_data_drv   = '0;
      lfsr_state     = 32'h6d3c_6369;
      err_count      = 0;
      check_count    = 0;
      test_count     = 0;
      cur_test       = "reset";
      for (int i = 0; i < N_AEG; i++) begin
         model_aeg[i] = '0;
      end
      for (int i = 0; i < N_PE; i++) begin
         model_acc[i] = '0;
      end
      repeat (5) @(posedge clk);
      r_reset <= 1'b0;
      @(negedge clk);

      begin_test("reset_state");
      check_flag("idle", 1'b1, cae_idle_o);
      check_flag("stall", 1'b0, cae_stall_o);
      read_aeg(0);
      read_aeg(1);
      end_test();

      begin_test("aeg_write_read");
      write_aeg(1, rand_bits(64));
      read_aeg(1);
      write_aeg(0, rand_bits(64));
      read_aeg(0);
      read_aeg(1);
      end_test();

      begin_test("exceptions");
      write_aeg(2, rand_bits(64));
      read_aeg(5);
      send_inst(KIND_CUSTOM, 5'd5, 0, '0, 2'b01, 1'b0, '0);
      send_inst(3'd6, 5'd0, 0, '0, 2'b01, 1'b0, '0);
      send_inst(KIND_CUSTOM, CAEP_NOP0, 0, '0, 2'b00, 1'b0, '0);
      send_inst(KIND_CUSTOM, CAEP_NOP2, 0, '0, 2'b00, 1'b0, '0);
      read_aeg(0);
      read_aeg(1);
      end_test();

      begin_test("accumulate_return");
      write_aeg(0, make_word(OP_RST, 4'd0, '0));
      run_issue();
      for (int k = 0; k < 8; k++) begin
         // the first add always goes to every element
         // targets past the last element turn into broadcast
         r   = rand_bits(3);
         pe  = (k == 0 || int'(r[2:0]) >= N_PE) ? PE_BROADCAST : {1'b0, r[2:0]};
         tmp = rand_bits(48);
         write_aeg(0, make_word(OP_ADD, pe, {8'h00, tmp[47:0]}));
         run_issue();
         read_aeg(0);
      end
      for (int k = 0; k < N_PE; k++) begin
         write_aeg(0, make_word(OP_RETURN, 4'(k), '0));
         run_issue();
         read_aeg(0);
      end
      // a second clear has to wipe what the adds built up
      write_aeg(0, make_word(OP_RST, 4'd0, '0));
      run_issue();
      for (int k = 0; k < N_PE; k++) begin
         tmp = rand_bits(56);
         write_aeg(0, make_word(OP_RETURN, 4'(k), tmp[55:0]));
         run_issue();
         read_aeg(0);
      end
      end_test();

      begin_test("busy_window");
      tmp = rand_bits(48);
      write_aeg(0, make_word(OP_ADD, 4'd2, {8'h00, tmp[47:0]}));
      run_issue();
      read_aeg(0);
      end_test();

      begin_test("return_missing_pe");
      tmp = rand_bits(56);
      write_aeg(0, make_word(OP_RETURN, 4'd9, tmp[55:0]));
      run_issue();
      read_aeg(0);
      end_test();

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- hw/cae_pers_top.sv
`timescale 1ns/1ps

module cae_pers_top #(
   parameter int N_PE      = 4,
   parameter int PE_STAGES = 2
) (
   input  logic                clk,
   input  logic                r_reset,
   input  spmv_pkg::cae_inst_t cae_inst_i,
   input  logic [63:0]         cae_data_i,
   input  logic                cae_inst_vld_i,
   output logic [63:0]         cae_ret_data_o,
   output logic                cae_ret_data_vld_o,
   output spmv_pkg::cae_exc_t  cae_exception_o,
   output logic                cae_idle_o,
   output logic                cae_stall_o
);
   import spmv_pkg::*;

   logic     aeg_wr;
   logic     aeg_rd;
   logic     aeg_idx_sel;
   logic     issue;
   pe_word_u aeg0_word;
   logic     ret_we;
   pe_word_u ret_word;
   logic     chain_done;

   // index 0 is the head, index N_PE the drain
   pe_word_u        chain_word [N_PE+1];
   logic [N_PE:0]   chain_vld;

   cae_decode u_decode (
      .clk             (clk),
      .r_reset         (r_reset),
      .cae_inst_i      (cae_inst_i),
      .cae_inst_vld_i  (cae_inst_vld_i),
      .aeg_wr_o        (aeg_wr),
      .aeg_rd_o        (aeg_rd),
      .aeg_idx_sel_o   (aeg_idx_sel),
      .issue_o         (issue),
      .cae_exception_o (cae_exception_o)
   );

   aeg_regs u_aeg (
      .clk                (clk),
      .r_reset            (r_reset),
      .cae_data_i         (cae_data_i),
      .aeg_wr_i           (aeg_wr),
      .aeg_rd_i           (aeg_rd),
      .aeg_idx_sel_i      (aeg_idx_sel),
      .ret_we_i           (ret_we),
      .ret_word_i         (ret_word),
      .aeg0_word_o        (aeg0_word),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o)
   );

   pe_issue u_issue (
      .clk          (clk),
      .r_reset      (r_reset),
      .issue_i      (issue),
      .aeg0_word_i  (aeg0_word),
      .chain_done_i (chain_done),
      .head_word_o  (chain_word[0]),
      .head_vld_o   (chain_vld[0]),
      .cae_idle_o   (cae_idle_o),
      .cae_stall_o  (cae_stall_o)
   );

   // ******************************
   // systolic element row
   // ******************************

   for (genvar g = 0; g < N_PE; g++) begin : gen_pe
      spmv_pe #(
         .PE_ID     (g),
         .PE_STAGES (PE_STAGES)
      ) u_pe (
         .clk     (clk),
         .r_reset (r_reset),
         .word_i  (chain_word[g]),
         .vld_i   (chain_vld[g]),
         .word_o  (chain_word[g+1]),
         .vld_o   (chain_vld[g+1])
      );
   end

   pe_collect u_collect (
      .word_i       (chain_word[N_PE]),
      .vld_i        (chain_vld[N_PE]),
      .ret_we_o     (ret_we),
      .ret_word_o   (ret_word),
      .chain_done_o (chain_done)
   );

endmodule

//--- pe_chain/pe_collect.sv
`timescale 1ns/1ps

module pe_collect (
   input  spmv_pkg::pe_word_u word_i,
   input  logic               vld_i,
   output logic               ret_we_o,
   output spmv_pkg::pe_word_u ret_word_o,
   output logic               chain_done_o
);
   import spmv_pkg::*;

   logic is_return;

   // any word leaving the chain ends the busy window
   assign chain_done_o = vld_i;

   // only return words go back to AEG0, whether an element answered or not
   assign is_return  = (word_i.ret.opcode == OP_RETURN);
   assign ret_we_o   = vld_i && is_return;
   assign ret_word_o = word_i;

endmodule

//--- pe_chain/spmv_pe.sv
`timescale 1ns/1ps

module spmv_pe #(
   parameter int PE_ID     = 0,
   parameter int PE_STAGES = 2
) (
   input  logic               clk,
   input  logic               r_reset,
   input  spmv_pkg::pe_word_u word_i,
   input  logic               vld_i,
   output spmv_pkg::pe_word_u word_o,
   output logic               vld_o
);
   import spmv_pkg::*;

   accum_t                 acc_q;
   pe_word_u               next_word;
   pe_word_u               stage_word [PE_STAGES];
   logic [PE_STAGES-1:0]   stage_vld;
   logic                   hit;

   assign hit = (word_i.cmd.pe == 4'(PE_ID));

   // ******************************
   // accumulator
   // ******************************

   always_ff @(posedge clk) begin
      if (r_reset) begin
         acc_q <= '0;
      end else if (vld_i) begin
         case (word_i.cmd.opcode)
            OP_RST: acc_q <= '0;
            OP_ADD: begin
               if (hit || word_i.cmd.pe == PE_BROADCAST) begin
                  acc_q <= acc_q + word_i.cmd.operand;
               end
            end
            default: ;
         endcase
      end
   end

   // return aimed here picks up the accumulator
   always_comb begin
      next_word = word_i;
      if (word_i.cmd.opcode == OP_RETURN && hit) begin
         next_word.ret.value = 56'(acc_q);
      end
   end

   // ******************************
   // chain stages
   // ******************************

   always_ff @(posedge clk) begin
      if (r_reset) begin
         stage_vld <= '0;
      end else begin
         stage_vld[0] <= vld_i;
         for (int s = 1; s < PE_STAGES; s++) begin
            stage_vld[s] <= stage_vld[s-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      stage_word[0] <= next_word;
      for (int s = 1; s < PE_STAGES; s++) begin
         stage_word[s] <= stage_word[s-1];
      end
   end

   assign word_o = stage_word[PE_STAGES-1];
   assign vld_o  = stage_vld[PE_STAGES-1];

endmodule

//--- pe_chain/pe_issue.sv
`timescale 1ns/1ps

module pe_issue (
   input  logic               clk,
   input  logic               r_reset,
   input  logic               issue_i,
   input  spmv_pkg::pe_word_u aeg0_word_i,
   input  logic               chain_done_i,
   output spmv_pkg::pe_word_u head_word_o,
   output logic               head_vld_o,
   output logic               cae_idle_o,
   output logic               cae_stall_o
);
   import spmv_pkg::*;

   pe_word_u head_word_q;
   logic     head_vld_q;
   logic     busy_q;
   logic     accept;

   // a second issue while the chain is busy is dropped
   assign accept = issue_i && !busy_q;

   always_ff @(posedge clk) begin
      if (r_reset) begin
         head_vld_q <= 1'b0;
      end else begin
         head_vld_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         head_word_q <= aeg0_word_i;
      end
   end

   // busy from the head cycle until the word drains
   always_ff @(posedge clk) begin
      if (r_reset) begin
         busy_q <= 1'b0;
      end else if (accept) begin
         busy_q <= 1'b1;
      end else if (chain_done_i) begin
         busy_q <= 1'b0;
      end
   end

   assign head_word_o = head_word_q;
   assign head_vld_o  = head_vld_q;
   assign cae_stall_o = busy_q;
   assign cae_idle_o  = !busy_q;

endmodule

//--- hw/aeg_regs.sv
`timescale 1ns/1ps

module aeg_regs (
   input  logic               clk,
   input  logic               r_reset,
   input  logic [63:0]        cae_data_i,
   input  logic               aeg_wr_i,
   input  logic               aeg_rd_i,
   input  logic               aeg_idx_sel_i,
   input  logic               ret_we_i,
   input  spmv_pkg::pe_word_u ret_word_i,
   output spmv_pkg::pe_word_u aeg0_word_o,
   output logic [63:0]        cae_ret_data_o,
   output logic               cae_ret_data_vld_o
);
   import spmv_pkg::*;

   logic [63:0] aeg_q [N_AEG];
   logic [63:0] rd_data_q;
   logic        rd_vld_q;

   // ******************************
   // register file
   // ******************************

   // a host write overrides a write-back in the same cycle
   always_ff @(posedge clk) begin
      if (r_reset) begin
         for (int i = 0; i < N_AEG; i++) begin
            aeg_q[i] <= '0;
         end
      end else begin
         if (ret_we_i) begin
            aeg_q[0] <= ret_word_i;
         end
         if (aeg_wr_i) begin
            aeg_q[aeg_idx_sel_i] <= cae_data_i;
         end
      end
   end

   assign aeg0_word_o = aeg_q[0];

   // ******************************
   // host read return
   // ******************************

   always_ff @(posedge clk) begin
      if (r_reset) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= aeg_rd_i;
      end
   end

   // registered read data
   always_ff @(posedge clk) begin
      if (aeg_rd_i) begin
         rd_data_q <= aeg_q[aeg_idx_sel_i];
      end
   end

   assign cae_ret_data_o     = rd_data_q;
   assign cae_ret_data_vld_o = rd_vld_q;

endmodule

//--- hw/cae_decode.sv
`timescale 1ns/1ps

module cae_decode (
   input  logic                clk,
   input  logic                r_reset,
   input  spmv_pkg::cae_inst_t cae_inst_i,
   input  logic                cae_inst_vld_i,
   output logic                aeg_wr_o,
   output logic                aeg_rd_o,
   output logic                aeg_idx_sel_o,
   output logic                issue_o,
   output spmv_pkg::cae_exc_t  cae_exception_o
);
   import spmv_pkg::*;

   logic     is_wr;
   logic     is_rd;
   logic     is_custom;
   logic     bad_kind;
   logic     bad_caep;
   logic     idx_ok;
   cae_exc_t exc_q;

   always_comb begin
      is_wr     = 1'b0;
      is_rd     = 1'b0;
      is_custom = 1'b0;
      bad_kind  = 1'b0;
      if (cae_inst_vld_i) begin
         case (cae_inst_i.kind)
            KIND_NONE:   ;
            KIND_AEG_WR: is_wr = 1'b1;
            KIND_AEG_RD: is_rd = 1'b1;
            KIND_CUSTOM: is_custom = 1'b1;
            default:     bad_kind = 1'b1;
         endcase
      end
   end

   assign idx_ok = cae_inst_i.aeg_idx < 18'(N_AEG);

   // bad index never reaches the register file
   assign aeg_wr_o      = is_wr && idx_ok;
   assign aeg_rd_o      = is_rd && idx_ok;
   assign aeg_idx_sel_o = cae_inst_i.aeg_idx[0];

   assign issue_o  = is_custom && (cae_inst_i.caep == CAEP_ISSUE);
   assign bad_caep = is_custom && (cae_inst_i.caep != CAEP_NOP0) &&
                     (cae_inst_i.caep != CAEP_ISSUE) && (cae_inst_i.caep != CAEP_NOP2);

   // one-cycle exception pulses
   always_ff @(posedge clk) begin
      if (r_reset) begin
         exc_q <= '0;
      end else begin
         exc_q.aegidx_err <= (is_wr || is_rd) && !idx_ok;
         exc_q.unimpl_err <= bad_kind || bad_caep;
      end
   end

   assign cae_exception_o = exc_q;

endmodule

//--- common/spmv_pkg.sv
package spmv_pkg;

   // ******************************
   // dispatch instruction
   // ******************************

   localparam logic [2:0] KIND_NONE    = 3'd0;
   localparam logic [2:0] KIND_AEG_WR  = 3'd1;
   localparam logic [2:0] KIND_AEG_RD  = 3'd2;
   localparam logic [2:0] KIND_CUSTOM  = 3'd3;

   // custom opcodes 0 and 2 are accepted without effect
   localparam logic [4:0] CAEP_NOP0    = 5'd0;
   localparam logic [4:0] CAEP_ISSUE   = 5'd1;
   localparam logic [4:0] CAEP_NOP2    = 5'd2;

   localparam int N_AEG = 2;

   typedef struct packed {
      logic [2:0]  kind;
      logic [4:0]  caep;
      logic [5:0]  unused;
      logic [17:0] aeg_idx;
   } cae_inst_t;

   typedef struct packed {
      logic aegidx_err;
      logic unimpl_err;
   } cae_exc_t;

   // ******************************
   // chain words
   // ******************************

   typedef logic [47:0] accum_t;

   typedef enum logic [3:0] {
      OP_NOP    = 4'd0,
      OP_RST    = 4'd1,
      OP_ADD    = 4'd2,
      OP_RETURN = 4'd3
   } pe_op_e;

   // target 15 reaches every element on an add
   localparam logic [3:0] PE_BROADCAST = 4'd15;

   typedef struct packed {
      pe_op_e      opcode;
      logic [3:0]  pe;
      logic [7:0]  pad;
      accum_t      operand;
   } pe_cmd_t;

   typedef struct packed {
      pe_op_e      opcode;
      logic [3:0]  pe;
      logic [55:0] value;
   } pe_ret_t;

   // the same 64 bits are read as a command on the way in
   // and as a return once an element has answered
   typedef union packed {
      pe_cmd_t cmd;
      pe_ret_t ret;
   } pe_word_u;

endpackage
